// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= tb_is
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: src/is.sv
module is import is_pkg::*;
(
   input  logic              clk,
   input  logic              arst_n_i,
   input  disp_inst_t        disp_i [DISP_PORTS],
   input  wake_t             wake_i [WAKE_PORTS],
   input  logic [FU_CNT-1:0] fu_rdy_i,
   input  brn_evt_t          flush_i,
   input  brn_evt_t          cmt_i,
   output logic              ful_o,
   output iss_inst_t         mul_iss_o,
   output iss_inst_t         alu1_iss_o,
   output iss_inst_t         alu2_iss_o,
   output iss_inst_t         adr_iss_o
);

   logic [DISP_PORTS-1:0] disp_vld;
   logic [ISQ_DEPTH-1:0]  lin_en;
   logic [ISQ_DEPTH-1:0]  port_sel;
   logic [ISQ_DEPTH-1:0]  occ;
   logic [ISQ_DEPTH-1:0]  kill;
   logic [ISQ_DEPTH-1:0]  iss_free;
   logic [ISQ_DEPTH-1:0]  src_rdy;
   logic [BRN_BITS-1:0]   brn_clr;
   logic                  ful;
   isq_line_t             isq_line [ISQ_DEPTH];

   ////////////////////////////////////////////////////////////
   // branch event decode
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      for (int p = 0; p < DISP_PORTS; p++)
         disp_vld[p] = disp_i[p].vld;
      // flush kills every live entry behind the named branch
      for (int i = 0; i < ISQ_DEPTH; i++)
         kill[i] = flush_i.vld & occ[i] & isq_line[i].brn_mask[flush_i.idx];
   end

   assign brn_clr = cmt_i.vld ? (BRN_BITS'(1) << cmt_i.idx) : '0;
   assign ful_o   = ful;

   ////////////////////////////////////////////////////////////
   // blocks
   ////////////////////////////////////////////////////////////
   is_counter i_counter (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .disp_vld_i (disp_vld),
      .occ_i      (occ),
      .kill_i     (kill),
      .iss_free_i (iss_free),
      .lin_en_o   (lin_en),
      .port_sel_o (port_sel),
      .ful_o      (ful)
   );

   is_isq i_isq (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .disp_i     (disp_i),
      .lin_en_i   (lin_en),
      .port_sel_i (port_sel),
      .kill_i     (kill),
      .iss_free_i (iss_free),
      .brn_clr_i  (brn_clr),
      .isq_line_o (isq_line),
      .occ_o      (occ)
   );

   is_tpu i_tpu (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .disp_i     (disp_i),
      .lin_en_i   (lin_en),
      .port_sel_i (port_sel),
      .isq_line_i (isq_line),
      .wake_i     (wake_i),
      .src_rdy_o  (src_rdy)
   );

   is_pdc i_pdc (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .isq_line_i (isq_line),
      .occ_i      (occ),
      .src_rdy_i  (src_rdy),
      .kill_i     (kill),
      .fu_rdy_i   (fu_rdy_i),
      .iss_free_o (iss_free),
      .mul_iss_o  (mul_iss_o),
      .alu1_iss_o (alu1_iss_o),
      .alu2_iss_o (alu2_iss_o),
      .adr_iss_o  (adr_iss_o)
   );

endmodule

// File: src/is_counter.sv
module is_counter import is_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  logic [DISP_PORTS-1:0] disp_vld_i,
   input  logic [ISQ_DEPTH-1:0]  occ_i,
   input  logic [ISQ_DEPTH-1:0]  kill_i,
   input  logic [ISQ_DEPTH-1:0]  iss_free_i,
   output logic [ISQ_DEPTH-1:0]  lin_en_o,
   output logic [ISQ_DEPTH-1:0]  port_sel_o,
   output logic                  ful_o
);

   logic [CNT_BITS-1:0] cnt_q;
   logic [CNT_BITS-1:0] wr_cnt;
   logic [CNT_BITS-1:0] rm_cnt;

   ////////////////////////////////////////////////////////////
   // slot allocation
   ////////////////////////////////////////////////////////////
   // lowest free entry goes to the lowest pending port
   always_comb
   begin
      logic [DISP_PORTS-1:0] pend;
      logic                  sel;
      pend       = disp_vld_i & {DISP_PORTS{~ful_o}};
      sel        = 1'b0;
      lin_en_o   = '0;
      port_sel_o = '0;
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         if (!occ_i[i] && (pend != '0))
         begin
            for (int p = DISP_PORTS - 1; p >= 0; p--)
            begin
               if (pend[p])
                  sel = 1'(p);
            end
            lin_en_o[i]   = 1'b1;
            port_sel_o[i] = sel;
            pend[sel]     = 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // occupancy count
   ////////////////////////////////////////////////////////////
   assign wr_cnt = CNT_BITS'($countones(lin_en_o));
   // only live entries leave the queue
   assign rm_cnt = CNT_BITS'($countones(occ_i & (kill_i | iss_free_i)));

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         cnt_q <= '0;
      else
         cnt_q <= cnt_q + wr_cnt - rm_cnt;
   end

   // full once a whole dispatch group no longer fits
   assign ful_o = cnt_q > CNT_BITS'(ISQ_DEPTH - DISP_PORTS);

   a_cnt_max: assert property (@(posedge clk) disable iff (!arst_n_i)
      cnt_q <= CNT_BITS'(ISQ_DEPTH));

   a_cnt_occ: assert property (@(posedge clk) disable iff (!arst_n_i)
      cnt_q == CNT_BITS'($countones(occ_i)));

endmodule

// File: src/is_isq.sv
module is_isq import is_pkg::*;
(
   input  logic                 clk,
   input  logic                 arst_n_i,
   input  disp_inst_t           disp_i [DISP_PORTS],
   input  logic [ISQ_DEPTH-1:0] lin_en_i,
   input  logic [ISQ_DEPTH-1:0] port_sel_i,
   input  logic [ISQ_DEPTH-1:0] kill_i,
   input  logic [ISQ_DEPTH-1:0] iss_free_i,
   input  logic [BRN_BITS-1:0]  brn_clr_i,
   output isq_line_t            isq_line_o [ISQ_DEPTH],
   output logic [ISQ_DEPTH-1:0] occ_o
);

   isq_line_t            line_q [ISQ_DEPTH];
   logic [ISQ_DEPTH-1:0] occ_q;

   // dispatch record to stored line with committed bits dropped
   function automatic isq_line_t to_line(input disp_inst_t d,
                                         input logic [BRN_BITS-1:0] clr);
      isq_line_t l;
      l.vld      = d.vld;
      l.fu       = d.fu;
      l.psrc1    = d.psrc1;
      l.psrc2    = d.psrc2;
      l.pdest    = d.pdest;
      l.brn_mask = d.brn_mask & ~clr;
      l.op       = d.op;
      return l;
   endfunction

   ////////////////////////////////////////////////////////////
   // entry valid bits
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         occ_q <= '0;
      end
      else
      begin
         for (int i = 0; i < ISQ_DEPTH; i++)
         begin
            if (lin_en_i[i])
               occ_q[i] <= 1'b1;
            else if (kill_i[i] || iss_free_i[i])
               occ_q[i] <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // entry payload
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         if (lin_en_i[i])
            line_q[i] <= to_line(disp_i[port_sel_i[i]], brn_clr_i);
         else
            line_q[i].brn_mask <= line_q[i].brn_mask & ~brn_clr_i;
      end
   end

   // stored vld goes stale after kill or issue so occ_q drives it
   always_comb
   begin
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         isq_line_o[i]     = line_q[i];
         isq_line_o[i].vld = occ_q[i];
      end
   end

   assign occ_o = occ_q;

   // allocation must only hand out entries that are free
   a_no_overwrite: assert property (@(posedge clk) disable iff (!arst_n_i)
      (lin_en_i & occ_q) == '0);

endmodule

// File: src/is_pdc.sv
module is_pdc import is_pkg::*;
(
   input  logic                 clk,
   input  logic                 arst_n_i,
   input  isq_line_t            isq_line_i [ISQ_DEPTH],
   input  logic [ISQ_DEPTH-1:0] occ_i,
   input  logic [ISQ_DEPTH-1:0] src_rdy_i,
   input  logic [ISQ_DEPTH-1:0] kill_i,
   input  logic [FU_CNT-1:0]    fu_rdy_i,
   output logic [ISQ_DEPTH-1:0] iss_free_o,
   output iss_inst_t            mul_iss_o,
   output iss_inst_t            alu1_iss_o,
   output iss_inst_t            alu2_iss_o,
   output iss_inst_t            adr_iss_o
);

   logic [ISQ_DEPTH-1:0] cand;
   logic [ISQ_DEPTH-1:0] is_mul;
   logic [ISQ_DEPTH-1:0] is_alu;
   logic [ISQ_DEPTH-1:0] is_adr;
   logic [ISQ_DEPTH-1:0] req [FU_CNT];
   logic [ISQ_DEPTH-1:0] gnt [FU_CNT];
   logic [FU_CNT-1:0]    gnt_vld;
   iss_inst_t            iss_d [FU_CNT];
   iss_inst_t            iss_q [FU_CNT];

   // keep only the lowest set bit
   function automatic logic [ISQ_DEPTH-1:0] lowest(input logic [ISQ_DEPTH-1:0] r);
      return r & (~r + ISQ_DEPTH'(1));
   endfunction

   function automatic logic [ISQ_IDX_BITS-1:0] enc(input logic [ISQ_DEPTH-1:0] oh);
      logic [ISQ_IDX_BITS-1:0] idx;
      idx = '0;
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         if (oh[i])
            idx = idx | ISQ_IDX_BITS'(i);
      end
      return idx;
   endfunction

   ////////////////////////////////////////////////////////////
   // priority decoders
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         // an entry killed this cycle is never picked
         cand[i]   = occ_i[i] & src_rdy_i[i] & ~kill_i[i];
         is_mul[i] = cand[i] & (isq_line_i[i].fu == FU_MULT);
         is_alu[i] = cand[i] & (isq_line_i[i].fu == FU_ALU);
         is_adr[i] = cand[i] & (isq_line_i[i].fu == FU_ADDR);
      end
      req[FU_MULT_BIT] = is_mul & {ISQ_DEPTH{fu_rdy_i[FU_MULT_BIT]}};
      req[FU_ADDR_BIT] = is_adr & {ISQ_DEPTH{fu_rdy_i[FU_ADDR_BIT]}};
      req[FU_ALU1_BIT] = is_alu & {ISQ_DEPTH{fu_rdy_i[FU_ALU1_BIT]}};
      gnt[FU_MULT_BIT] = lowest(req[FU_MULT_BIT]);
      gnt[FU_ADDR_BIT] = lowest(req[FU_ADDR_BIT]);
      gnt[FU_ALU1_BIT] = lowest(req[FU_ALU1_BIT]);
      // alu2 takes the next alu entry after alu1's pick
      req[FU_ALU2_BIT] = is_alu & ~gnt[FU_ALU1_BIT] & {ISQ_DEPTH{fu_rdy_i[FU_ALU2_BIT]}};
      gnt[FU_ALU2_BIT] = lowest(req[FU_ALU2_BIT]);
   end

   always_comb
   begin
      logic [ISQ_IDX_BITS-1:0] idx;
      iss_free_o = '0;
      for (int u = 0; u < FU_CNT; u++)
      begin
         idx              = enc(gnt[u]);
         gnt_vld[u]       = |gnt[u];
         iss_free_o       = iss_free_o | gnt[u];
         iss_d[u].vld     = gnt_vld[u];
         iss_d[u].isq_idx = idx;
         iss_d[u].psrc1   = isq_line_i[idx].psrc1;
         iss_d[u].psrc2   = isq_line_i[idx].psrc2;
         iss_d[u].pdest   = isq_line_i[idx].pdest;
         iss_d[u].op      = isq_line_i[idx].op;
      end
   end

   ////////////////////////////////////////////////////////////
   // issue registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         iss_q <= '{default: '0};
      else
         iss_q <= iss_d;
   end

   assign mul_iss_o  = iss_q[FU_MULT_BIT];
   assign alu1_iss_o = iss_q[FU_ALU1_BIT];
   assign alu2_iss_o = iss_q[FU_ALU2_BIT];
   assign adr_iss_o  = iss_q[FU_ADDR_BIT];

   // one entry per unit, so freed entries match granted units
   a_one_owner: assert property (@(posedge clk) disable iff (!arst_n_i)
      $countones(iss_free_o) == $countones(gnt_vld));

endmodule

// File: src/is_pkg.sv
package is_pkg;

   ////////////////////////////////////////////////////////////
   // queue and port sizes
   ////////////////////////////////////////////////////////////
   localparam int ISQ_DEPTH    = 16;
   localparam int ISQ_IDX_BITS = 4;
   // one extra bit so a full queue fits in the count
   localparam int CNT_BITS     = ISQ_IDX_BITS + 1;
   localparam int DISP_PORTS   = 2;
   localparam int PREG_BITS    = 6;
   localparam int WAKE_PORTS   = 4;
   localparam int BRN_BITS     = 4;
   localparam int BRN_IDX_BITS = 2;
   localparam int OP_BITS      = 16;
   localparam int FU_CNT       = 4;

   // bit order of fu_rdy and of the issue slots
   localparam int FU_MULT_BIT = 0;
   localparam int FU_ALU1_BIT = 1;
   localparam int FU_ALU2_BIT = 2;
   localparam int FU_ADDR_BIT = 3;

   ////////////////////////////////////////////////////////////
   // unit class and shared records
   ////////////////////////////////////////////////////////////
   typedef enum logic [1:0] {
      FU_MULT = 2'd0,
      FU_ALU  = 2'd1,
      FU_ADDR = 2'd2
   } fu_e;

   typedef struct packed {
      logic                    vld;
      fu_e                     fu;
      logic [PREG_BITS-1:0]    psrc1;
      logic                    psrc1_rdy;
      logic [PREG_BITS-1:0]    psrc2;
      logic                    psrc2_rdy;
      logic [PREG_BITS-1:0]    pdest;
      logic [BRN_BITS-1:0]     brn_mask;
      logic [OP_BITS-1:0]      op;
   } disp_inst_t;

   // ready bits are kept by the wakeup unit
   typedef struct packed {
      logic                    vld;
      fu_e                     fu;
      logic [PREG_BITS-1:0]    psrc1;
      logic [PREG_BITS-1:0]    psrc2;
      logic [PREG_BITS-1:0]    pdest;
      logic [BRN_BITS-1:0]     brn_mask;
      logic [OP_BITS-1:0]      op;
   } isq_line_t;

   typedef struct packed {
      logic                    vld;
      logic [PREG_BITS-1:0]    tag;
   } wake_t;

   typedef struct packed {
      logic                    vld;
      logic [BRN_IDX_BITS-1:0] idx;
   } brn_evt_t;

   typedef struct packed {
      logic                    vld;
      logic [ISQ_IDX_BITS-1:0] isq_idx;
      logic [PREG_BITS-1:0]    psrc1;
      logic [PREG_BITS-1:0]    psrc2;
      logic [PREG_BITS-1:0]    pdest;
      logic [OP_BITS-1:0]      op;
   } iss_inst_t;

endpackage

// File: src/is_tpu.sv
module is_tpu import is_pkg::*;
(
   input  logic                 clk,
   input  logic                 arst_n_i,
   input  disp_inst_t           disp_i [DISP_PORTS],
   input  logic [ISQ_DEPTH-1:0] lin_en_i,
   input  logic [ISQ_DEPTH-1:0] port_sel_i,
   input  isq_line_t            isq_line_i [ISQ_DEPTH],
   input  wake_t                wake_i [WAKE_PORTS],
   output logic [ISQ_DEPTH-1:0] src_rdy_o
);

   logic [ISQ_DEPTH-1:0]  rdy1_q;
   logic [ISQ_DEPTH-1:0]  rdy2_q;
   logic [ISQ_DEPTH-1:0]  hit1;
   logic [ISQ_DEPTH-1:0]  hit2;
   logic [DISP_PORTS-1:0] dhit1;
   logic [DISP_PORTS-1:0] dhit2;

   // any valid broadcast carrying this tag
   function automatic logic tag_hit(input logic [PREG_BITS-1:0] tag,
                                    input wake_t wk [WAKE_PORTS]);
      logic hit;
      hit = 1'b0;
      for (int w = 0; w < WAKE_PORTS; w++)
      begin
         if (wk[w].vld && (wk[w].tag == tag))
            hit = 1'b1;
      end
      return hit;
   endfunction

   ////////////////////////////////////////////////////////////
   // tag compare
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         hit1[i] = tag_hit(isq_line_i[i].psrc1, wake_i);
         hit2[i] = tag_hit(isq_line_i[i].psrc2, wake_i);
      end
      // same cycle match for instructions being dispatched
      for (int p = 0; p < DISP_PORTS; p++)
      begin
         dhit1[p] = tag_hit(disp_i[p].psrc1, wake_i);
         dhit2[p] = tag_hit(disp_i[p].psrc2, wake_i);
      end
   end

   ////////////////////////////////////////////////////////////
   // ready bits
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         rdy1_q <= '0;
         rdy2_q <= '0;
      end
      else
      begin
         for (int i = 0; i < ISQ_DEPTH; i++)
         begin
            if (lin_en_i[i])
            begin
               rdy1_q[i] <= disp_i[port_sel_i[i]].psrc1_rdy | dhit1[port_sel_i[i]];
               rdy2_q[i] <= disp_i[port_sel_i[i]].psrc2_rdy | dhit2[port_sel_i[i]];
            end
            else
            begin
               rdy1_q[i] <= rdy1_q[i] | hit1[i];
               rdy2_q[i] <= rdy2_q[i] | hit2[i];
            end
         end
      end
   end

   assign src_rdy_o = rdy1_q & rdy2_q;

endmodule

// File: tests/tb_is_checks.svh
`ifndef TB_IS_CHECKS_SVH
`define TB_IS_CHECKS_SVH

   int iss_errs = 0;
   int ful_errs = 0;

   ////////////////////////////////////////////////////////////
   // result compare
   ////////////////////////////////////////////////////////////
   function automatic string iss_text(input iss_inst_t i);
      return $sformatf("entry %0d src %0d %0d pdest %0d op %h",
                       i.isq_idx, i.psrc1, i.psrc2, i.pdest, i.op);
   endfunction

   // payload only matters when the slot is valid
   task automatic check_iss(input iss_inst_t got, input iss_inst_t exp, input string what);
      if (got.vld !== exp.vld)
      begin
         iss_errs++;
         $display("MISMATCH at %0t: %s vld is %0b, expected %0b",
                  $time, what, got.vld, exp.vld);
      end
      else if (exp.vld && (got !== exp))
      begin
         iss_errs++;
         $display("MISMATCH at %0t: %s %s, expected %s",
                  $time, what, iss_text(got), iss_text(exp));
      end
   endtask

   task automatic check_ful(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         ful_errs++;
         $display("MISMATCH at %0t: %s is %0b, expected %0b", $time, what, got, exp);
      end
   endtask

   function automatic string unit_name(input int u);
      case (u)
         FU_MULT_BIT: return "mul";
         FU_ALU1_BIT: return "alu1";
         FU_ALU2_BIT: return "alu2";
         default:     return "adr";
      endcase
   endfunction

`endif

// File: tests/tb_is.sv
module tb_is import is_pkg::*;
();

   localparam int N_ROWS  = 51;
   localparam int RST_TMO = 50;

   // one cycle of stimulus and the outputs expected after its edge
   typedef struct packed {
      disp_inst_t [DISP_PORTS-1:0] disp;
      wake_t [WAKE_PORTS-1:0]      wake;
      logic [FU_CNT-1:0]           fu_rdy;
      brn_evt_t                    flush;
      brn_evt_t                    cmt;
      logic                        ful;
      iss_inst_t [FU_CNT-1:0]      iss;
   } row_t;

   logic              clk;
   logic              arst_n_i;
   disp_inst_t        disp [DISP_PORTS];
   wake_t             wake [WAKE_PORTS];
   logic [FU_CNT-1:0] fu_rdy;
   brn_evt_t          flush;
   brn_evt_t          cmt;
   logic              ful;
   iss_inst_t         iss [FU_CNT];
   row_t              tbl [N_ROWS];
   int                seed = 68095;

   `include "tb_is_checks.svh"

   is i_dut (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .disp_i     (disp),
      .wake_i     (wake),
      .fu_rdy_i   (fu_rdy),
      .flush_i    (flush),
      .cmt_i      (cmt),
      .ful_o      (ful),
      .mul_iss_o  (iss[FU_MULT_BIT]),
      .alu1_iss_o (iss[FU_ALU1_BIT]),
      .alu2_iss_o (iss[FU_ALU2_BIT]),
      .adr_iss_o  (iss[FU_ADDR_BIT])
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial
   begin
      arst_n_i = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n_i = 1'b1;
   end

   // source tags below 8 count as already ready
   function automatic disp_inst_t make_inst(input fu_e fu,
                                            input logic [PREG_BITS-1:0] s1,
                                            input logic [PREG_BITS-1:0] s2,
                                            input logic [PREG_BITS-1:0] pd,
                                            input logic [BRN_BITS-1:0] mask);
      disp_inst_t d;
      d.vld       = 1'b1;
      d.fu        = fu;
      d.psrc1     = s1;
      d.psrc1_rdy = s1 < 6'd8;
      d.psrc2     = s2;
      d.psrc2_rdy = s2 < 6'd8;
      d.pdest     = pd;
      d.brn_mask  = mask;
      d.op        = OP_BITS'($random(seed));
      return d;
   endfunction

   // ent is the queue entry the instruction was allocated to
   task automatic expect_issue(input int row, input int unit, input int src_row,
                               input int port, input int ent);
      tbl[row].iss[unit].vld     = 1'b1;
      tbl[row].iss[unit].isq_idx = ISQ_IDX_BITS'(ent);
      tbl[row].iss[unit].psrc1   = tbl[src_row].disp[port].psrc1;
      tbl[row].iss[unit].psrc2   = tbl[src_row].disp[port].psrc2;
      tbl[row].iss[unit].pdest   = tbl[src_row].disp[port].pdest;
      tbl[row].iss[unit].op      = tbl[src_row].disp[port].op;
   endtask

   ////////////////////////////////////////////////////////////
   // stimulus and expected results
   ////////////////////////////////////////////////////////////
   task automatic build_table();
      for (int r = 0; r < N_ROWS; r++)
      begin
         tbl[r]        = '0;
         tbl[r].fu_rdy = '1;
      end
      // ready alu op
      tbl[0].disp[0] = make_inst(FU_ALU, 6'd1, 6'd2, 6'd32, 4'b0000);
      expect_issue(1, FU_ALU1_BIT, 0, 0, 0);
      // wakeup and then same cycle match at dispatch
      tbl[3].disp[0] = make_inst(FU_MULT, 6'd10, 6'd2, 6'd33, 4'b0000);
      tbl[3].disp[1] = make_inst(FU_ADDR, 6'd1, 6'd11, 6'd34, 4'b0000);
      tbl[5].wake[2] = '{vld: 1'b1, tag: 6'd10};
      tbl[6].wake[0] = '{vld: 1'b1, tag: 6'd11};
      expect_issue(6, FU_MULT_BIT, 3, 0, 0);
      tbl[7].disp[0] = make_inst(FU_ALU, 6'd12, 6'd2, 6'd35, 4'b0000);
      tbl[7].wake[1] = '{vld: 1'b1, tag: 6'd12};
      expect_issue(7, FU_ADDR_BIT, 3, 1, 1);
      expect_issue(8, FU_ALU1_BIT, 7, 0, 0);
      // three alu ops held and then picked by index
      tbl[10].disp[0] = make_inst(FU_ALU, 6'd1, 6'd2, 6'd36, 4'b0000);
      tbl[10].disp[1] = make_inst(FU_ALU, 6'd1, 6'd2, 6'd37, 4'b0000);
      tbl[11].disp[0] = make_inst(FU_ALU, 6'd1, 6'd2, 6'd38, 4'b0000);
      tbl[10].fu_rdy  = 4'b1001;
      tbl[11].fu_rdy  = 4'b1001;
      expect_issue(12, FU_ALU1_BIT, 10, 0, 0);
      expect_issue(12, FU_ALU2_BIT, 10, 1, 1);
      expect_issue(13, FU_ALU1_BIT, 11, 0, 2);
      // multiplier held alone
      tbl[14].disp[0] = make_inst(FU_MULT, 6'd1, 6'd2, 6'd39, 4'b0000);
      tbl[14].disp[1] = make_inst(FU_ALU, 6'd1, 6'd2, 6'd40, 4'b0000);
      tbl[15].fu_rdy  = 4'b1110;
      tbl[16].fu_rdy  = 4'b1110;
      expect_issue(15, FU_ALU1_BIT, 14, 1, 1);
      expect_issue(17, FU_MULT_BIT, 14, 0, 0);
      // flush of branch 1 kills the first op and the mul
      tbl[19].disp[0] = make_inst(FU_ALU, 6'd20, 6'd2, 6'd41, 4'b0010);
      tbl[19].disp[1] = make_inst(FU_ALU, 6'd21, 6'd2, 6'd42, 4'b0001);
      tbl[20].disp[0] = make_inst(FU_MULT, 6'd22, 6'd2, 6'd43, 4'b0010);
      tbl[21].flush   = '{vld: 1'b1, idx: 2'd1};
      tbl[22].wake[0] = '{vld: 1'b1, tag: 6'd20};
      tbl[22].wake[1] = '{vld: 1'b1, tag: 6'd21};
      tbl[22].wake[2] = '{vld: 1'b1, tag: 6'd22};
      expect_issue(23, FU_ALU1_BIT, 19, 1, 1);
      // commit of branch 2 protects against its later flush
      tbl[25].disp[0] = make_inst(FU_ALU, 6'd1, 6'd2, 6'd44, 4'b0100);
      tbl[25].disp[1] = make_inst(FU_ADDR, 6'd1, 6'd2, 6'd45, 4'b0100);
      for (int r = 25; r < 28; r++)
         tbl[r].fu_rdy = 4'b0001;
      tbl[26].cmt   = '{vld: 1'b1, idx: 2'd2};
      tbl[27].flush = '{vld: 1'b1, idx: 2'd2};
      expect_issue(28, FU_ALU1_BIT, 25, 0, 0);
      expect_issue(28, FU_ADDR_BIT, 25, 1, 1);
      // killed in its select cycle
      tbl[29].disp[0] = make_inst(FU_ALU, 6'd1, 6'd2, 6'd46, 4'b1000);
      tbl[30].flush   = '{vld: 1'b1, idx: 2'd3};
      // fill 15 entries and drop the extra pair sent while full
      for (int k = 0; k < 9; k++)
         tbl[32 + k].fu_rdy = '0;
      for (int k = 0; k < 7; k++)
      begin
         for (int p = 0; p < DISP_PORTS; p++)
            tbl[32 + k].disp[p] = make_inst(FU_ALU, 6'd1, 6'd2, 6'(k * 2 + p), 4'b0000);
      end
      tbl[39].disp[0] = make_inst(FU_ALU, 6'd1, 6'd2, 6'd14, 4'b0000);
      tbl[40].disp[0] = make_inst(FU_ALU, 6'd1, 6'd2, 6'd15, 4'b0000);
      tbl[40].disp[1] = make_inst(FU_ALU, 6'd1, 6'd2, 6'd16, 4'b0000);
      tbl[39].ful     = 1'b1;
      tbl[40].ful     = 1'b1;
      tbl[41].fu_rdy  = 4'b0010;
      tbl[42].fu_rdy  = '0;
      expect_issue(41, FU_ALU1_BIT, 32, 0, 0);
      // drain two per cycle from entry 1 upward
      for (int k = 0; k < 7; k++)
      begin
         expect_issue(43 + k, FU_ALU1_BIT, 32 + k, 1, 2 * k + 1);
         expect_issue(43 + k, FU_ALU2_BIT, 33 + k, 0, 2 * k + 2);
      end
   endtask

   task automatic apply_row(input int r);
      for (int p = 0; p < DISP_PORTS; p++)
         disp[p] = tbl[r].disp[p];
      for (int w = 0; w < WAKE_PORTS; w++)
         wake[w] = tbl[r].wake[w];
      fu_rdy = tbl[r].fu_rdy;
      flush  = tbl[r].flush;
      cmt    = tbl[r].cmt;
   endtask

   task automatic check_row(input int r);
      check_ful(ful, tbl[r].ful, $sformatf("row %0d ful_o", r));
      for (int u = 0; u < FU_CNT; u++)
         check_iss(iss[u], tbl[r].iss[u], $sformatf("row %0d %s", r, unit_name(u)));
   endtask

   ////////////////////////////////////////////////////////////
   // run
   ////////////////////////////////////////////////////////////
   initial
   begin
      int wait_cnt;
      fu_rdy = '0;
      flush  = '0;
      cmt    = '0;
      for (int p = 0; p < DISP_PORTS; p++)
         disp[p] = '0;
      for (int w = 0; w < WAKE_PORTS; w++)
         wake[w] = '0;
      build_table();
      wait_cnt = 0;
      while ((arst_n_i !== 1'b1) && (wait_cnt < RST_TMO))
      begin
         @(negedge clk);
         wait_cnt++;
      end
      if (arst_n_i !== 1'b1)
      begin
         $display("reset was not released within %0d cycles", RST_TMO);
         $display("TB FAILED");
         $finish;
      end
      else
      begin
         check_ful(ful, 1'b0, "after reset ful_o");
         for (int u = 0; u < FU_CNT; u++)
            check_iss(iss[u], '0, $sformatf("after reset %s", unit_name(u)));
         for (int r = 0; r < N_ROWS; r++)
         begin
            apply_row(r);
            @(posedge clk);
            @(negedge clk);
            check_row(r);
         end
         $display("errors: issue %0d, full %0d", iss_errs, ful_errs);
         if ((iss_errs + ful_errs) == 0)
            $display("TB PASSED");
         else
            $display("TB FAILED");
         $finish;
      end
   end

endmodule

// File: vlog.f
+incdir+tests
src/is_pkg.sv
src/is_counter.sv
src/is_isq.sv
src/is_tpu.sv
src/is_pdc.sv
src/is.sv
tests/tb_is.sv
